// File: bench/tb_evr_link_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "evr_settings.svh"

module tb_evr_link_tx;

    typedef struct packed {
        logic                     active;
        logic                     idle;     // Word must be all zero
        evr_link_pkg::slot_t      slot;
        evr_link_pkg::link_byte_t dbus;
    } expect_t;

    logic                       clk = 1'b0;
    logic                       rst_i;
    logic                       enable_i;
    logic                       clear_i;
    evr_ctrl_pkg::presc_t       presc_i;
    evr_link_pkg::link_byte_t   dbus_i;
    evr_link_pkg::link_byte_t   seg_num_i;
    logic                       seg_wr_i;
    evr_ctrl_pkg::seg_addr_t    seg_waddr_i;
    evr_link_pkg::link_byte_t   seg_wdata_i;
    evr_link_pkg::link_word_t   tx_word_o;
    evr_link_pkg::link_k_t      tx_k_o;

    // Reference model
    evr_link_pkg::link_byte_t   seg_model [`EVR_SEG_BYTES];
    evr_link_pkg::slot_t        slot_model = '0;
    evr_ctrl_pkg::event_code_t  exp_code = 8'h01;
    expect_t                    pend = '0;
    int                         codes_seen = 0;
    int                         errors = 0;
    int                         test_errors = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;

    evr_link_tx u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .enable_i    (enable_i),
        .clear_i     (clear_i),
        .presc_i     (presc_i),
        .dbus_i      (dbus_i),
        .seg_num_i   (seg_num_i),
        .seg_wr_i    (seg_wr_i),
        .seg_waddr_i (seg_waddr_i),
        .seg_wdata_i (seg_wdata_i),
        .tx_word_o   (tx_word_o),
        .tx_k_o      (tx_k_o)
    );

    always #20 clk = ~clk;

    task automatic report_fail(input string msg);
        begin
            errors++;
            $display("[FAIL] %0t: %s", $time, msg);
        end
    endtask

    // Reset or disabled leaves a zero word one clock later
    idle_zero: assert property (@(posedge clk)
        (rst_i || !enable_i) |=> (tx_word_o == '0 && tx_k_o == '0))
    else
        report_fail("link word not zero after reset or disable");

    function automatic evr_ctrl_pkg::event_code_t next_code(input evr_ctrl_pkg::event_code_t c);
        return evr_ctrl_pkg::event_code_t'((int'(c) % 255) + 1);    // Zero is never a code
    endfunction

    function automatic evr_ctrl_pkg::csum_t checksum();
        evr_ctrl_pkg::csum_t sum;
        sum = {8'h00, seg_num_i};
        for (int i = 0; i < `EVR_SEG_BYTES; i++)
            sum = sum + {8'h00, seg_model[i]};
        return `EVR_CSUM_SEED - sum;
    endfunction

    // Expected data-lane byte with the frame laid out over odd slots
    function automatic evr_link_pkg::lane_out_t expected_data(input evr_link_pkg::slot_t s,
                                                              input evr_link_pkg::link_byte_t dbus);
        evr_link_pkg::lane_out_t r;
        evr_ctrl_pkg::csum_t     cs;
        int                      pos;
        r   = '0;
        cs  = checksum();
        pos = int'(s) / 2;
        if (s[0] == 1'b0)
            r.value = dbus;
        else if (pos == 0)
        begin
            r.value = `EVR_K_START;
            r.is_k  = 1'b1;
        end
        else if (pos == 1)
            r.value = seg_num_i;
        else if (pos <= `EVR_SEG_BYTES + 1)
            r.value = seg_model[pos - 2];
        else if (pos == `EVR_SEG_BYTES + 2)
        begin
            r.value = `EVR_K_STOP;
            r.is_k  = 1'b1;
        end
        else if (pos == `EVR_SEG_BYTES + 3)
            r.value = cs[15:8];
        else if (pos == `EVR_SEG_BYTES + 4)
            r.value = cs[7:0];
        return r;                                   // Pad bytes stay zero
    endfunction

    task automatic check_word(input expect_t e);
        evr_link_pkg::lane_out_t  exp_data;
        evr_link_pkg::link_byte_t ev;
        begin
            ev = tx_word_o.event_byte;
            if (e.idle)
            begin
                assert (tx_word_o == '0 && tx_k_o == '0)
                else report_fail($sformatf("idle word %h k %b", tx_word_o, tx_k_o));
            end
            else
            begin
                if (int'(e.slot) % `EVR_COMMA_PERIOD == 0)
                begin
                    assert (ev == `EVR_K_COMMA && tx_k_o[1])
                    else report_fail($sformatf("slot %0d: comma missing, event byte %h k %b",
                                               e.slot, ev, tx_k_o));
                end
                else
                begin
                    assert (!tx_k_o[1])
                    else report_fail($sformatf("slot %0d: event K flag set", e.slot));
                    if (ev != 8'h00)
                    begin
                        assert (ev == exp_code)
                        else report_fail($sformatf("slot %0d: event code %h, expected %h",
                                                   e.slot, ev, exp_code));
                        exp_code = next_code(exp_code);
                        codes_seen++;
                    end
                end
                exp_data = expected_data(e.slot, e.dbus);
                assert (tx_word_o.data_byte == exp_data.value && tx_k_o[0] == exp_data.is_k)
                else report_fail($sformatf("slot %0d: data byte %h k %b, expected %h k %b",
                                           e.slot, tx_word_o.data_byte, tx_k_o[0],
                                           exp_data.value, exp_data.is_k));
            end
        end
    endtask

    // Inputs are stable at the falling edge and outputs have settled since the rising edge
    always @(negedge clk)
    begin
        if (pend.active)
            check_word(pend);
        if (rst_i || clear_i)
            exp_code = 8'h01;                       // Generator restarts
        pend.active = 1'b1;
        pend.idle   = rst_i || !enable_i;
        pend.slot   = slot_model;
        pend.dbus   = dbus_i;
        if (rst_i || !enable_i)
            slot_model = '0;
        else
            slot_model = evr_link_pkg::slot_t'((int'(slot_model) + 1) % `EVR_SLOTS);
    end

    task automatic step();
        begin
            @(posedge clk);
            #2;
            dbus_i = evr_link_pkg::link_byte_t'($urandom);
        end
    endtask

    task automatic run_cycles(input int n);
        begin
            repeat (n) step();
        end
    endtask

    task automatic write_segment();
        begin
            for (int a = 0; a < `EVR_SEG_BYTES; a++)
            begin
                seg_wr_i     = 1'b1;
                seg_waddr_i  = evr_ctrl_pkg::seg_addr_t'(a);
                seg_wdata_i  = evr_link_pkg::link_byte_t'($urandom);
                seg_model[a] = seg_wdata_i;
                step();
            end
            seg_wr_i = 1'b0;
        end
    endtask

    task automatic wait_codes(input int target, input int limit);
        int n;
        begin
            n = 0;
            while (codes_seen < target && n < limit)
            begin
                step();
                n++;
            end
            if (codes_seen < target)
            begin
                errors++;
                $display("Timeout: only %0d of %0d event codes arrived within %0d cycles",
                         codes_seen, target, limit);
            end
        end
    endtask

    task automatic finish_test(input string name);
        begin
            if (errors == test_errors)
            begin
                tests_passed++;
                $display("Test %s: passed", name);
            end
            else
            begin
                tests_failed++;
                $display("Test %s: failed with %0d errors", name, errors - test_errors);
            end
            test_errors = errors;
        end
    endtask

    initial
    begin
        void'($urandom(32'hfc43));
        rst_i       = 1'b1;
        enable_i    = 1'b0;
        clear_i     = 1'b0;
        presc_i     = evr_ctrl_pkg::presc_t'(3);
        dbus_i      = '0;
        seg_num_i   = '0;
        seg_wr_i    = 1'b0;
        seg_waddr_i = '0;
        seg_wdata_i = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_i = 1'b0;
        run_cycles(4);
        finish_test("reset_idle");

        // Commas, bus bytes and segment frames
        presc_i   = evr_ctrl_pkg::presc_t'(3 + ($urandom % 18));
        seg_num_i = evr_link_pkg::link_byte_t'($urandom);
        write_segment();
        enable_i = 1'b1;
        run_cycles(3 * `EVR_SLOTS);
        enable_i = 1'b0;
        run_cycles(4);
        finish_test("frames");

        // FIFO fills while disabled and then drains through the code wrap
        presc_i = evr_ctrl_pkg::presc_t'(3 + ($urandom % 18));
        run_cycles((int'(presc_i) + 1) * (`EVR_FIFO_DEPTH + 4));
        enable_i = 1'b1;
        wait_codes(codes_seen + 300, 300 * 25);
        enable_i = 1'b0;
        run_cycles(4);
        finish_test("backpressure");

        // Queued codes dropped by clear
        run_cycles((int'(presc_i) + 1) * 10);
        clear_i = 1'b1;
        run_cycles(2);
        clear_i  = 1'b0;
        enable_i = 1'b1;
        wait_codes(codes_seen + 20, 20 * 25 + `EVR_SLOTS);
        enable_i = 1'b0;
        run_cycles(4);
        finish_test("clear");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/evr_ctrl_pkg.sv
`default_nettype none

`include "evr_settings.svh"

package evr_ctrl_pkg;

    typedef logic [7:0]  event_code_t;
    typedef logic [30:0] presc_t;       // Prescaler compare value
    typedef logic [15:0] csum_t;

    // Extra MSB is the wrap bit
    typedef logic [$clog2(`EVR_FIFO_DEPTH):0] fifo_ptr_t;

    typedef logic [$clog2(`EVR_SEG_BYTES)-1:0] seg_addr_t;

    // Byte role in the segmented-data frame
    typedef enum logic [2:0] {
        FP_START,
        FP_SEGNUM,
        FP_DATA,
        FP_STOP,
        FP_CSUM_HI,
        FP_CSUM_LO,
        FP_PAD
    } frame_pos_e;

endpackage

`default_nettype wire

// File: hw/evr_data_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "evr_settings.svh"

module evr_data_lane (
    input  logic                        clk,
    input  logic                        rst_i,
    input  evr_link_pkg::slot_t         slot_i,
    input  logic                        slot_valid_i,
    input  evr_link_pkg::link_byte_t    dbus_i,
    input  evr_link_pkg::link_byte_t    seg_num_i,
    input  logic                        seg_wr_i,
    input  evr_ctrl_pkg::seg_addr_t     seg_waddr_i,
    input  evr_link_pkg::link_byte_t    seg_wdata_i,
    output evr_link_pkg::lane_out_t     lane_o
);

    localparam int SLOT_W    = $bits(evr_link_pkg::slot_t);
    localparam int ADDR_W    = $bits(evr_ctrl_pkg::seg_addr_t);
    localparam int DATA_LAST = `EVR_SEG_BYTES + 1;   // Last payload position

    evr_link_pkg::link_byte_t  seg_buf [`EVR_SEG_BYTES];
    evr_ctrl_pkg::seg_addr_t   rd_addr;
    evr_ctrl_pkg::frame_pos_e  frame_pos;
    evr_ctrl_pkg::csum_t       csum_acc;
    evr_ctrl_pkg::csum_t       csum_out;
    evr_link_pkg::link_byte_t  frame_byte;

    logic [SLOT_W-2:0] frame_idx;
    logic [SLOT_W-2:0] data_off;
    logic              frame_k;
    logic              odd_slot;

    assign odd_slot  = slot_i[0];
    assign frame_idx = slot_i[SLOT_W-1:1];      // Two slots per frame byte
    assign data_off  = frame_idx - 2'd2;
    assign rd_addr   = data_off[ADDR_W-1:0];
    assign csum_out  = `EVR_CSUM_SEED - csum_acc;

    always_ff @(posedge clk)
    begin
        if (seg_wr_i)
            seg_buf[seg_waddr_i] <= seg_wdata_i;
    end

    // Frame sequencer
    always_comb
    begin
        if (frame_idx == 0)
            frame_pos = evr_ctrl_pkg::FP_START;
        else if (frame_idx == 1)
            frame_pos = evr_ctrl_pkg::FP_SEGNUM;
        else if (int'(frame_idx) <= DATA_LAST)
            frame_pos = evr_ctrl_pkg::FP_DATA;
        else if (int'(frame_idx) == DATA_LAST + 1)
            frame_pos = evr_ctrl_pkg::FP_STOP;
        else if (int'(frame_idx) == DATA_LAST + 2)
            frame_pos = evr_ctrl_pkg::FP_CSUM_HI;
        else if (int'(frame_idx) == DATA_LAST + 3)
            frame_pos = evr_ctrl_pkg::FP_CSUM_LO;
        else
            frame_pos = evr_ctrl_pkg::FP_PAD;
    end

    always_comb
    begin
        frame_byte = '0;
        frame_k    = 1'b0;
        case (frame_pos)
            evr_ctrl_pkg::FP_START:
            begin
                frame_byte = `EVR_K_START;
                frame_k    = 1'b1;
            end
            evr_ctrl_pkg::FP_SEGNUM:  frame_byte = seg_num_i;
            evr_ctrl_pkg::FP_DATA:    frame_byte = seg_buf[rd_addr];
            evr_ctrl_pkg::FP_STOP:
            begin
                frame_byte = `EVR_K_STOP;
                frame_k    = 1'b1;
            end
            evr_ctrl_pkg::FP_CSUM_HI: frame_byte = csum_out[15:8];   // MSB first
            evr_ctrl_pkg::FP_CSUM_LO: frame_byte = csum_out[7:0];
            default:                  frame_byte = '0;                // Pad
        endcase
    end

    // Running sum over segment number and payload as they go out
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            csum_acc <= '0;
        end
        else if (slot_valid_i && odd_slot)
        begin
            case (frame_pos)
                evr_ctrl_pkg::FP_START:  csum_acc <= '0;
                evr_ctrl_pkg::FP_SEGNUM,
                evr_ctrl_pkg::FP_DATA:   csum_acc <= csum_acc + {8'h00, frame_byte};
                default:                 csum_acc <= csum_acc;
            endcase
        end
    end

    // Even slots carry the distributed bus
    always_comb
    begin
        lane_o = '0;
        if (slot_valid_i)
        begin
            if (odd_slot)
            begin
                lane_o.value = frame_byte;
                lane_o.is_k  = frame_k;
            end
            else
            begin
                lane_o.value = dbus_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/evr_event_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "evr_settings.svh"

module evr_event_lane (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      clear_i,
    input  evr_ctrl_pkg::presc_t      presc_i,
    input  evr_link_pkg::slot_t       slot_i,
    input  logic                      slot_valid_i,
    output evr_link_pkg::lane_out_t   lane_o
);

    localparam int PTR_W = $bits(evr_ctrl_pkg::fifo_ptr_t);

    evr_ctrl_pkg::presc_t      presc_cnt;
    evr_ctrl_pkg::event_code_t ev_code;
    evr_ctrl_pkg::event_code_t next_code;
    evr_ctrl_pkg::event_code_t fifo_mem [`EVR_FIFO_DEPTH];
    evr_ctrl_pkg::fifo_ptr_t   wr_ptr;
    evr_ctrl_pkg::fifo_ptr_t   rd_ptr;

    logic fifo_empty;
    logic fifo_full;
    logic push;
    logic pop;
    logic comma_slot;

    // Code sequence skips zero, 0 is the null event
    assign next_code = (ev_code == 8'hFF) ? 8'h01 : ev_code + 8'h01;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]) &&
                        (wr_ptr[PTR_W-2:0] == rd_ptr[PTR_W-2:0]);

    // Prescaler frozen while full so nothing is dropped
    assign push = !fifo_full && (presc_cnt >= presc_i);

    assign comma_slot = (int'(slot_i) % `EVR_COMMA_PERIOD) == 0;
    assign pop        = slot_valid_i && !comma_slot && !fifo_empty;

    // Test-event generator
    always_ff @(posedge clk)
    begin
        if (rst_i || clear_i)
        begin
            presc_cnt <= '0;
            ev_code   <= '0;
        end
        else if (!fifo_full)
        begin
            if (push)
            begin
                presc_cnt <= '0;
                ev_code   <= next_code;     // Same value goes into the FIFO
            end
            else
            begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i || clear_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr[PTR_W-2:0]] <= next_code;
    end

    // Comma insertion, otherwise FIFO head or null byte
    always_comb
    begin
        lane_o = '0;
        if (slot_valid_i)
        begin
            if (comma_slot)
            begin
                lane_o.value = `EVR_K_COMMA;
                lane_o.is_k  = 1'b1;
            end
            else if (!fifo_empty)
            begin
                lane_o.value = fifo_mem[rd_ptr[PTR_W-2:0]];     // Popped this cycle
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/evr_lane_combiner.sv
`timescale 1ns/100ps
`default_nettype none

`include "evr_settings.svh"

module evr_lane_combiner (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        enable_i,
    input  evr_link_pkg::lane_out_t     ev_lane_i,
    input  evr_link_pkg::lane_out_t     data_lane_i,
    output evr_link_pkg::slot_t         slot_o,
    output logic                        slot_valid_o,
    output evr_link_pkg::link_word_t    tx_word_o,
    output evr_link_pkg::link_k_t       tx_k_o
);

    localparam evr_link_pkg::slot_t SLOT_LAST = evr_link_pkg::slot_t'(`EVR_SLOTS - 1);

    evr_link_pkg::slot_t slot_q;

    assign slot_o       = slot_q;
    assign slot_valid_o = enable_i;

    // Held at 0 while disabled so the first slot after enable is 0
    always_ff @(posedge clk)
    begin
        if (rst_i || !enable_i)
        begin
            slot_q <= '0;
        end
        else if (slot_q == SLOT_LAST)
        begin
            slot_q <= '0;
        end
        else
        begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // Output register, one clock behind the slot index
    always_ff @(posedge clk)
    begin
        if (rst_i || !enable_i)
        begin
            tx_word_o <= '0;
            tx_k_o    <= '0;
        end
        else
        begin
            tx_word_o.event_byte <= ev_lane_i.value;
            tx_word_o.data_byte  <= data_lane_i.value;
            tx_k_o               <= {ev_lane_i.is_k, data_lane_i.is_k};
        end
    end

endmodule

`default_nettype wire

// File: hw/evr_link_pkg.sv
`default_nettype none

`include "evr_settings.svh"

package evr_link_pkg;

    // One byte lane of the link word
    typedef logic [7:0] link_byte_t;

    // Slot index within the frame cycle
    typedef logic [$clog2(`EVR_SLOTS)-1:0] slot_t;

    // K flags, bit 1 event lane, bit 0 data lane
    typedef logic [1:0] link_k_t;

    typedef struct packed {
        link_byte_t event_byte;     // 15:8
        link_byte_t data_byte;      // 7:0
    } link_word_t;

    // Per-lane result for the current slot
    typedef struct packed {
        link_byte_t value;
        logic       is_k;
    } lane_out_t;

endpackage

`default_nettype wire

// File: hw/evr_link_tx.sv
`timescale 1ns/100ps
`default_nettype none

module evr_link_tx (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        enable_i,
    input  logic                        clear_i,
    input  evr_ctrl_pkg::presc_t        presc_i,
    input  evr_link_pkg::link_byte_t    dbus_i,
    input  evr_link_pkg::link_byte_t    seg_num_i,
    input  logic                        seg_wr_i,
    input  evr_ctrl_pkg::seg_addr_t     seg_waddr_i,
    input  evr_link_pkg::link_byte_t    seg_wdata_i,
    output evr_link_pkg::link_word_t    tx_word_o,
    output evr_link_pkg::link_k_t       tx_k_o
);

    evr_link_pkg::slot_t     slot;
    logic                    slot_valid;
    evr_link_pkg::lane_out_t ev_lane;
    evr_link_pkg::lane_out_t data_lane;

    evr_event_lane u_event_lane (
        .clk          (clk),
        .rst_i        (rst_i),
        .clear_i      (clear_i),
        .presc_i      (presc_i),
        .slot_i       (slot),
        .slot_valid_i (slot_valid),
        .lane_o       (ev_lane)
    );

    evr_data_lane u_data_lane (
        .clk          (clk),
        .rst_i        (rst_i),
        .slot_i       (slot),
        .slot_valid_i (slot_valid),
        .dbus_i       (dbus_i),
        .seg_num_i    (seg_num_i),
        .seg_wr_i     (seg_wr_i),
        .seg_waddr_i  (seg_waddr_i),
        .seg_wdata_i  (seg_wdata_i),
        .lane_o       (data_lane)
    );

    evr_lane_combiner u_combiner (
        .clk          (clk),
        .rst_i        (rst_i),
        .enable_i     (enable_i),
        .ev_lane_i    (ev_lane),
        .data_lane_i  (data_lane),
        .slot_o       (slot),
        .slot_valid_o (slot_valid),
        .tx_word_o    (tx_word_o),
        .tx_k_o       (tx_k_o)
    );

endmodule

`default_nettype wire

// File: hw/evr_settings.svh
`ifndef EVR_SETTINGS_SVH
`define EVR_SETTINGS_SVH

// Link framing
`define EVR_SLOTS         64        // Slots per frame cycle
`define EVR_COMMA_PERIOD  4         // Comma on event lane every N slots

// Event FIFO
`define EVR_FIFO_DEPTH    16

// Segmented data
`define EVR_SEG_BYTES     16        // Payload bytes per segment

// 8b/10b control characters
`define EVR_K_COMMA       8'hBC     // K28.5
`define EVR_K_START       8'h5C     // K28.2, segment start
`define EVR_K_STOP        8'h3C     // K28.1, segment stop

// Checksum is seed minus byte sum
`define EVR_CSUM_SEED     16'hFFFF

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, pass is decided from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_evr_link_tx -Mdir obj_dir -o sim_evr \
    && ./obj_dir/sim_evr | tee /dev/stderr | grep -qx "Simulation finished: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// File: sources.f
+incdir+hw
hw/evr_link_pkg.sv
hw/evr_ctrl_pkg.sv
hw/evr_event_lane.sv
hw/evr_data_lane.sv
hw/evr_lane_combiner.sv
hw/evr_link_tx.sv
bench/tb_evr_link_tx.sv
